//--- compile.f
logic/uart_pkg.sv
logic/capture_pkg.sv
logic/uart_rx.sv
logic/cmd_assembler.sv
logic/capture_ctrl.sv
logic/sample_fifo.sv
logic/uart_tx.sv
logic/hex_dump_top.sv
testbench/tb_clock.sv
testbench/hex_dump_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps --top-module hex_dump_tb \
    -f compile.f -o hex_dump_sim
output=$(./obj_dir/hex_dump_sim || true)
echo "$output"
if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

//--- testbench/hex_dump_tb.sv
`timescale 1ns/1ps

module hex_dump_tb;

    localparam int bit_cycles     = 8;
    localparam int depth          = 32;
    localparam int rounds         = 12;
    localparam int frame_cycles   = 10 * bit_cycles;
    localparam int idle_window    = 12 * bit_cycles;
    // per round 4 two-byte commands in, at most 33 frames out, plus trigger waits
    localparam int timeout_cycles = rounds * (2 * 4 + 33) * frame_cycles + 20000;

    logic        clk;
    logic        rst_n;
    logic        rx;
    logic        tx;
    logic [7:0]  probe;
    logic [31:0] rng;
    logic [7:0]  rx_bytes [$];   // bytes decoded from tx
    int          cycle_count = 0;

    tb_clock #(.period_ns(40)) u_clock (.clk(clk));

    hex_dump_top #(
        .clks_per_bit (bit_cycles),
        .fifo_depth   (depth)
    ) uut (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .probe (probe),
        .tx    (tx)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first failure");
    endtask

    // probe counts every cycle, so captured samples step by one
    always @(posedge clk) begin
        #1 probe = probe + 8'd1;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d clock cycles", timeout_cycles);
            abort_run();
        end
    end

    // serial decoder sampling tx at falling clock edges near mid-bit
    initial begin : tx_decoder
        logic [7:0] data;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && tx === 1'b0) begin
                repeat (bit_cycles / 2) @(negedge clk);
                assert (tx === 1'b0) else begin
                    $display("decoder: start bit on tx did not stay low until mid-bit");
                    abort_run();
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (bit_cycles) @(negedge clk);
                    data[i] = tx;   // LSB first
                end
                repeat (bit_cycles) @(negedge clk);
                assert (tx === 1'b1) else begin
                    $display("decoder: frame on tx ended with a low stop bit");
                    abort_run();
                end
                rx_bytes.push_back(data);
            end
        end
    end

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};   // stop, data, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1 rx = frame[i];
            repeat (bit_cycles - 1) @(posedge clk);
        end
    endtask

    task automatic send_cmd(input logic [7:0] ctrl, input logic [7:0] data);
        send_byte(ctrl);
        send_byte(data);
    endtask

    task automatic wait_line_idle(input int cycles);
        int idle;
        idle = 0;
        while (idle < cycles) begin
            @(negedge clk);
            if (tx === 1'b1) begin
                idle++;
            end else begin
                idle = 0;   // activity restarts the window
            end
        end
    endtask

    task automatic check_dump(input logic [7:0] mask, input logic [7:0] value,
                              input int expected);
        logic [7:0] want;
        assert (rx_bytes.size() == expected) else begin
            $display("error: tx byte count got %h expected %h", rx_bytes.size(), expected);
            abort_run();
        end
        if (expected > 0) begin
            assert ((rx_bytes[0] & mask) == (value & mask)) else begin
                $display("error: tx first byte %h fails match, value %h mask %h",
                         rx_bytes[0], value, mask);
                abort_run();
            end
        end
        for (int i = 1; i < expected; i++) begin
            want = rx_bytes[i-1] + 8'd1;
            assert (rx_bytes[i] == want) else begin
                $display("error: tx byte %0d got %h expected %h", i, rx_bytes[i], want);
                abort_run();
            end
        end
        rx_bytes.delete();
    endtask

    initial begin : stimulus
        logic [7:0] mask;
        logic [7:0] value;
        logic [7:0] count;
        int         expected;
        rng   = 32'hccb4;
        rx    = 1'b1;
        rst_n = 1'b0;
        rng   = xorshift32(rng);
        probe = rng[7:0];   // random start for the probe counter
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        // quiet line before any command
        for (int i = 0; i < 20 * bit_cycles; i++) begin
            @(negedge clk);
            assert (tx === 1'b1) else begin
                $display("error: tx got %h expected %h before any command", tx, 1'b1);
                abort_run();
            end
        end

        for (int r = 0; r < rounds; r++) begin
            rng   = xorshift32(rng);
            mask  = rng[7:0];
            value = rng[15:8];
            count = rng[23:16];
            if (r == 3) begin
                count = 8'd0;
            end else if (r % 4 == 1) begin
                count = 8'd33 + (count % 8'd200);   // above the FIFO depth
            end else begin
                count = 8'd1 + {3'b000, count[4:0]};
            end
            if (r == 5) begin
                mask = 8'h00;   // triggers on the first armed cycle
            end else if (r == 7) begin
                mask = 8'hff;
            end
            expected = (count > 8'd32) ? depth : int'(count);

            send_cmd(8'h00, mask);    // trigger mask
            send_cmd(8'h01, value);   // trigger value
            send_cmd(8'h02, count);   // sample count
            send_cmd(8'h80, 8'h00);   // dump
            while (rx_bytes.size() < expected) begin
                @(negedge clk);
            end
            wait_line_idle(idle_window);
            check_dump(mask, value, expected);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 40
) (
    output logic clk
);
    localparam int half_period = period_ns / 2;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;   // free-running, starts low
    end

endmodule

//--- logic/hex_dump_top.sv
`timescale 1ns/1ps

module hex_dump_top #(
    parameter int clks_per_bit = uart_pkg::default_clks_per_bit,
    parameter int fifo_depth   = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rx,
    input  capture_pkg::sample_t probe,
    output logic                 tx
);
    import uart_pkg::*;
    import capture_pkg::*;

    byte_t   rx_data;
    logic    rx_stb;
    byte_t   cmd_ctrl;
    byte_t   cmd_data;
    logic    cmd_req;
    logic    cmd_ack;
    sample_t fifo_din;
    sample_t fifo_dout;
    logic    fifo_wr;
    logic    fifo_rd;
    logic    fifo_empty;
    logic    fifo_full;

    uart_rx #(
        .clks_per_bit (clks_per_bit)
    ) u_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx      (rx),
        .rx_data (rx_data),
        .rx_stb  (rx_stb)
    );

    cmd_assembler u_cmd (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_data  (rx_data),
        .rx_stb   (rx_stb),
        .cmd_ack  (cmd_ack),
        .cmd_req  (cmd_req),
        .cmd_ctrl (cmd_ctrl),
        .cmd_data (cmd_data)
    );

    capture_ctrl #(
        .fifo_depth (fifo_depth)
    ) u_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_req   (cmd_req),
        .cmd_ctrl  (cmd_ctrl),
        .cmd_data  (cmd_data),
        .probe     (probe),
        .fifo_full (fifo_full),
        .cmd_ack   (cmd_ack),
        .fifo_wr   (fifo_wr),
        .fifo_din  (fifo_din)
    );

    sample_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_wr    (fifo_wr),
        .fifo_din   (fifo_din),
        .fifo_rd    (fifo_rd),
        .fifo_dout  (fifo_dout),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_dout  (fifo_dout),
        .fifo_empty (fifo_empty),
        .fifo_rd    (fifo_rd),
        .tx         (tx)
    );

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int clks_per_bit = uart_pkg::default_clks_per_bit
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  capture_pkg::sample_t fifo_dout,
    input  logic                 fifo_empty,
    output logic                 fifo_rd,
    output logic                 tx
);
    import uart_pkg::*;

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(clks_per_bit - 1);

    typedef enum logic [1:0] {tx_idle, tx_start, tx_bits, tx_stop} tx_state_t;

    tx_state_t        state;
    logic [cnt_w-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    logic             bit_done;
    logic             shift_en;
    byte_t            shift_reg;

    assign bit_done = (baud_cnt == full_cnt);

    // pop when idle, or at the very end of a stop bit for back-to-back frames
    assign fifo_rd = !fifo_empty && (state == tx_idle || (state == tx_stop && bit_done));

    assign shift_en = bit_done && (state == tx_start || (state == tx_bits && bit_idx != 3'd7));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= tx_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;
        end else if (fifo_rd) begin
            state    <= tx_start;
            baud_cnt <= '0;
            tx       <= 1'b0;   // start bit
        end else begin
            baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
            case (state)
                tx_idle: begin
                    baud_cnt <= '0;
                    tx       <= 1'b1;
                end
                tx_start: begin
                    if (bit_done) begin
                        bit_idx <= '0;
                        tx      <= shift_reg[0];
                        state   <= tx_bits;
                    end
                end
                tx_bits: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;   // stop bit
                            state <= tx_stop;
                        end else begin
                            tx <= shift_reg[0];
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        state <= tx_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd) begin
            shift_reg <= fifo_dout;
        end else if (shift_en) begin
            shift_reg <= shift_reg >> 1;   // LSB first
        end
    end

endmodule

//--- logic/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo #(
    parameter int fifo_depth = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fifo_wr,
    input  capture_pkg::sample_t fifo_din,
    input  logic                 fifo_rd,
    output capture_pkg::sample_t fifo_dout,
    output logic                 fifo_empty,
    output logic                 fifo_full
);
    import capture_pkg::*;

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int occ_w = $clog2(fifo_depth + 1);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(fifo_depth - 1);

    sample_t          mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [occ_w-1:0] occupancy;
    logic             do_wr;
    logic             do_rd;

    assign do_wr      = fifo_wr && !fifo_full;   // overflow ignored
    assign do_rd      = fifo_rd && !fifo_empty;
    assign fifo_empty = (occupancy == '0);
    assign fifo_full  = (occupancy == occ_w'(fifo_depth));
    assign fifo_dout  = mem[rd_ptr];             // head word, fall-through

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= fifo_din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: ;   // both or neither
            endcase
        end
    end

endmodule

//--- logic/capture_ctrl.sv
`timescale 1ns/1ps

module capture_ctrl #(
    parameter int fifo_depth = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_req,
    input  uart_pkg::byte_t      cmd_ctrl,
    input  uart_pkg::byte_t      cmd_data,
    input  capture_pkg::sample_t probe,
    input  logic                 fifo_full,
    output logic                 cmd_ack,
    output logic                 fifo_wr,
    output capture_pkg::sample_t fifo_din
);
    import capture_pkg::*;

    localparam int rem_w = $clog2(fifo_depth + 1);

    capture_state_t   state;
    sample_t          trig_mask;
    sample_t          trig_value;
    logic [7:0]       count_reg;
    logic [rem_w-1:0] remaining;
    logic [rem_w-1:0] sat_count;
    reg_addr_t        addr;
    logic             is_dump;
    logic             accept;
    logic             match;

    assign addr    = cmd_ctrl[1:0];
    assign is_dump = cmd_ctrl[dump_bit];

    // a dump waits until the previous capture is done
    assign accept = cmd_req && !cmd_ack && (!is_dump || state == cap_idle);

    assign sat_count = (int'(count_reg) > fifo_depth) ? rem_w'(fifo_depth) : rem_w'(count_reg);
    assign match     = ((probe ^ trig_value) & trig_mask) == '0;

    assign fifo_wr  = !fifo_full &&
                      (state == cap_fill || (state == cap_armed && match && remaining != '0));
    assign fifo_din = probe;   // raw sample, unmasked

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_ack    <= 1'b0;
            state      <= cap_idle;
            trig_mask  <= '0;
            trig_value <= '0;
            count_reg  <= '0;
            remaining  <= '0;
        end else begin
            if (accept) begin
                cmd_ack <= 1'b1;
            end else if (!cmd_req) begin
                cmd_ack <= 1'b0;
            end

            if (accept && !is_dump) begin
                case (addr)
                    reg_trig_mask:  trig_mask  <= cmd_data;
                    reg_trig_value: trig_value <= cmd_data;
                    reg_count:      count_reg  <= cmd_data;
                    default: ;
                endcase
            end

            case (state)
                cap_idle: begin
                    if (accept && is_dump) begin
                        state     <= cap_armed;
                        remaining <= sat_count;
                    end
                end
                cap_armed: begin
                    if (remaining == '0) begin
                        state <= cap_idle;   // empty dump
                    end else if (fifo_wr) begin
                        remaining <= remaining - 1'b1;
                        state     <= (remaining == rem_w'(1)) ? cap_idle : cap_fill;
                    end
                end
                cap_fill: begin
                    if (fifo_wr) begin
                        remaining <= remaining - 1'b1;
                        if (remaining == rem_w'(1)) begin
                            state <= cap_idle;
                        end
                    end
                end
                default: state <= cap_idle;
            endcase
        end
    end

endmodule

//--- logic/cmd_assembler.sv
`timescale 1ns/1ps

module cmd_assembler (
    input  logic            clk,
    input  logic            rst_n,
    input  uart_pkg::byte_t rx_data,
    input  logic            rx_stb,
    input  logic            cmd_ack,
    output logic            cmd_req,
    output uart_pkg::byte_t cmd_ctrl,
    output uart_pkg::byte_t cmd_data
);

    logic byte_phase;   // 0 waits for control, 1 for data
    logic hs_open;

    // handshake is open until ack has fallen again
    assign hs_open = cmd_req | cmd_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_phase <= 1'b0;
            cmd_req    <= 1'b0;
        end else begin
            if (cmd_req && cmd_ack) begin
                cmd_req <= 1'b0;   // ack seen, release
            end else if (rx_stb && !hs_open) begin
                byte_phase <= ~byte_phase;
                if (byte_phase) begin
                    cmd_req <= 1'b1;   // second byte completes the command
                end
            end
        end
    end

    // command words stay frozen while the handshake is open
    always_ff @(posedge clk) begin
        if (rx_stb && !hs_open) begin
            if (byte_phase) begin
                cmd_data <= rx_data;
            end else begin
                cmd_ctrl <= rx_data;
            end
        end
    end

endmodule

//--- logic/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int clks_per_bit = uart_pkg::default_clks_per_bit
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rx,
    output uart_pkg::byte_t rx_data,
    output logic            rx_stb
);
    import uart_pkg::*;

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);

    typedef enum logic [1:0] {rx_idle, rx_start, rx_bits, rx_stop} rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [cnt_w-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    logic             bit_done;
    byte_t            shift_reg;

    assign bit_done = (baud_cnt == full_cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;   // line idles high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= rx_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_stb   <= 1'b0;
        end else begin
            rx_stb <= 1'b0;
            case (state)
                rx_idle: begin
                    baud_cnt <= '0;
                    if (!rx_sync) begin
                        state <= rx_start;   // falling start edge
                    end
                end
                rx_start: begin
                    if (baud_cnt == half_cnt) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_sync ? rx_idle : rx_bits;   // glitch goes back to idle
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                rx_bits: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_done) begin
                        rx_stb <= rx_sync;   // low stop bit drops the frame
                        state  <= rx_idle;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // data path, sampled mid-bit, LSB first
    always_ff @(posedge clk) begin
        if (state == rx_bits && bit_done) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
        if (state == rx_stop && bit_done && rx_sync) begin
            rx_data <= shift_reg;
        end
    end

endmodule

//--- logic/capture_pkg.sv
package capture_pkg;

    typedef logic [7:0] sample_t;     // one probe sample
    typedef logic [1:0] reg_addr_t;   // register select in the control byte

    localparam reg_addr_t reg_trig_mask  = 2'd0;
    localparam reg_addr_t reg_trig_value = 2'd1;
    localparam reg_addr_t reg_count      = 2'd2;   // address 3 has no register

    // control byte bit that requests a dump
    localparam int dump_bit = 7;

    typedef enum logic [1:0] {
        cap_idle,
        cap_armed,   // waiting for masked trigger match
        cap_fill     // storing one sample per clock
    } capture_state_t;

endpackage

//--- logic/uart_pkg.sv
package uart_pkg;

    // one byte on the serial line
    typedef logic [7:0] byte_t;

    // 48 MHz clock at 1 Mbaud
    localparam int default_clks_per_bit = 48;

endpackage
